//--- jacobian_engine.f
src/jac_pkg.sv
src/jac_ifs.sv
src/operand_sequencer.sv
src/operand_bank.sv
src/mac_unit.sv
src/jacobian_engine.sv
test/tb_clock_gen.sv
test/jacobian_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run from the project root; exit status is non-zero on failure.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module jacobian_engine_tb \
	-f jacobian_engine.f -o jacobian_sim \
	&& ./obj_dir/jacobian_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"

//--- src/jac_ifs.sv
// internal links of the matrix engine. operand_if is read_req_if delayed by one
// cycle in the operand bank, with the two operands added.
`timescale 1ns/1ps
`default_nettype none

// one read request per cycle while valid is high.
interface read_req_if;
	logic          valid;
	jac_pkg::idx_t idx_a;
	jac_pkg::idx_t idx_b;
	logic          first;
	logic          last;
	jac_pkg::idx_t out_idx;

	modport requester (
		output valid, idx_a, idx_b, first, last, out_idx
	);

	modport responder (
		input valid, idx_a, idx_b, first, last, out_idx
	);
endinterface

// operand pair with the schedule tags of the request that fetched it.
interface operand_if;
	logic          valid;
	jac_pkg::fix_t op_a;
	jac_pkg::fix_t op_b;
	logic          first;
	logic          last;
	jac_pkg::idx_t out_idx;

	modport source (
		output valid, op_a, op_b, first, last, out_idx
	);

	modport sink (
		input valid, op_a, op_b, first, last, out_idx
	);
endinterface

`default_nettype wire

//--- src/jac_pkg.sv
// shared fixed-point types for the 3x3 matrix engine.
// operands and results are signed 18-bit values, and the fraction width is set at the top level.
`default_nettype none

package jac_pkg;

	// matrices are always 3x3, stored row-major.
	localparam int DIM    = 3;
	localparam int N_ELEM = DIM * DIM;

	// signed operand and result word.
	typedef logic signed [17:0] fix_t;

	// full-width product of two operands.
	typedef logic signed [35:0] prod_t;

	// the accumulator has two bits of headroom for a sum of three products.
	typedef logic signed [37:0] acc_t;

	// element index 0 to 8.
	typedef logic [3:0] idx_t;

	typedef enum logic {
		MODE_MATRIX = 1'b0,
		MODE_ARRAY  = 1'b1
	} mult_mode_t;

	typedef enum logic {
		SEQ_IDLE = 1'b0,
		SEQ_RUN  = 1'b1
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/jacobian_engine.sv
// 3x3 matrix or element-wise product through one shared MAC. mode 0 is matrix, 1 is array.
// operands must be written while idle; results arrive as strobes with no back-pressure.
`timescale 1ns/1ps
`default_nettype none

module jacobian_engine #(
	parameter int unsigned FRAC_BITS = 15
) (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          wr_en,
	input  wire logic          wr_sel,
	input  wire jac_pkg::idx_t wr_idx,
	input  wire jac_pkg::fix_t wr_data,
	input  wire logic          start,
	input  wire logic          mode,
	output logic               busy,
	output logic               res_valid,
	output jac_pkg::idx_t      res_idx,
	output jac_pkg::fix_t      res_data,
	output logic               done
);

	read_req_if rd_if ();
	operand_if  op_if ();

	operand_sequencer sequencer_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.mode  (jac_pkg::mult_mode_t'(mode)),
		.busy  (busy),
		.done  (done),
		.rd    (rd_if.requester)
	);

	operand_bank bank_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.rd      (rd_if.responder),
		.op      (op_if.source)
	);

	mac_unit #(
		.FRAC_BITS (FRAC_BITS)
	) mac_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.op        (op_if.sink),
		.res_valid (res_valid),
		.res_idx   (res_idx),
		.res_data  (res_data)
	);

endmodule

`default_nettype wire

//--- src/mac_unit.sv
// two-stage multiply-accumulate. results are floor-shifted by FRAC_BITS (0 to 17)
// and saturated to 18 bits. there is no stall, so a result is lost if not taken.
`timescale 1ns/1ps
`default_nettype none

module mac_unit #(
	parameter int unsigned FRAC_BITS = 15
) (
	input  wire logic      clk,
	input  wire logic      rst_n,
	operand_if.sink        op,
	output logic           res_valid,
	output jac_pkg::idx_t  res_idx,
	output jac_pkg::fix_t  res_data
);

	localparam int          FIX_W  = $bits(jac_pkg::fix_t);
	localparam jac_pkg::acc_t SAT_HI = jac_pkg::acc_t'((longint'(1) << (FIX_W - 1)) - 1);
	localparam jac_pkg::acc_t SAT_LO = -SAT_HI - jac_pkg::acc_t'(1);

	logic           p_valid;
	jac_pkg::prod_t p_prod;
	logic           p_first;
	logic           p_last;
	jac_pkg::idx_t  p_idx;
	jac_pkg::acc_t  acc_q;
	jac_pkg::acc_t  acc_next;
	jac_pkg::acc_t  scaled;
	logic           acc_open_q;

	// stage 1 is the multiply register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p_valid <= 1'b0;
		end else begin
			p_valid <= op.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (op.valid) begin
			p_prod  <= op.op_a * op.op_b;
			p_first <= op.first;
			p_last  <= op.last;
			p_idx   <= op.out_idx;
		end
	end

	// a first tag starts a fresh sum; the product is sign-extended into the accumulator.
	assign acc_next = p_first ? jac_pkg::acc_t'(p_prod) : acc_q + jac_pkg::acc_t'(p_prod);
	assign scaled   = acc_next >>> FRAC_BITS;

	// stage 2 accumulates and emits the saturated result on the last tag.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid  <= 1'b0;
			acc_open_q <= 1'b0;
		end else begin
			res_valid <= p_valid && p_last;
			if (p_valid) begin
				acc_open_q <= !p_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (p_valid) begin
			acc_q <= acc_next;
		end
		if (p_valid && p_last) begin
			res_idx <= p_idx;
			if (scaled > SAT_HI) begin
				res_data <= jac_pkg::fix_t'(SAT_HI);
			end else if (scaled < SAT_LO) begin
				res_data <= jac_pkg::fix_t'(SAT_LO);
			end else begin
				res_data <= jac_pkg::fix_t'(scaled);
			end
		end
	end

	// the sequencer must close every sum before opening the next one.
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		(p_valid && p_first) |-> !acc_open_q);

endmodule

`default_nettype wire

//--- src/operand_bank.sv
// holds A and B as nine registers each. writes during a run are not supported.
// reads take one cycle and carry the request tags along.
`timescale 1ns/1ps
`default_nettype none

module operand_bank (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          wr_en,
	input  wire logic          wr_sel,
	input  wire jac_pkg::idx_t wr_idx,
	input  wire jac_pkg::fix_t wr_data,
	read_req_if.responder      rd,
	operand_if.source          op
);

	jac_pkg::fix_t mat_a [jac_pkg::N_ELEM];
	jac_pkg::fix_t mat_b [jac_pkg::N_ELEM];

	// wr_sel picks B when high.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < jac_pkg::N_ELEM; i++) begin
				mat_a[i] <= '0;
				mat_b[i] <= '0;
			end
		end else if (wr_en) begin
			if (wr_sel) begin
				mat_b[wr_idx] <= wr_data;
			end else begin
				mat_a[wr_idx] <= wr_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op.valid <= 1'b0;
		end else begin
			op.valid <= rd.valid;
		end
	end

	// operands and tags are loaded together so they leave the bank in step.
	always_ff @(posedge clk) begin
		if (rd.valid) begin
			op.op_a    <= mat_a[rd.idx_a];
			op.op_b    <= mat_b[rd.idx_b];
			op.first   <= rd.first;
			op.last    <= rd.last;
			op.out_idx <= rd.out_idx;
		end
	end

	a_wr_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_idx < jac_pkg::N_ELEM));

endmodule

`default_nettype wire

//--- src/operand_sequencer.sv
// turns a start pulse into 27 (matrix) or 9 (array) read requests, one per cycle.
// start is ignored while busy, which covers the three-cycle drain after the last request.
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                start,
	input  wire jac_pkg::mult_mode_t mode,
	output logic                     busy,
	output logic                     done,
	read_req_if.requester            rd
);

	localparam logic [4:0] LAST_MAT = 5'(jac_pkg::N_ELEM * jac_pkg::DIM - 1);
	localparam logic [4:0] LAST_ARR = 5'(jac_pkg::N_ELEM - 1);
	localparam logic [1:0] DIG_MAX  = 2'(jac_pkg::DIM - 1);

	jac_pkg::seq_state_t state_q;
	jac_pkg::mult_mode_t mode_q;
	logic [4:0]          step_q;
	logic [4:0]          last_step;
	logic [1:0]          k_q;
	logic [1:0]          col_q;
	logic [1:0]          row_q;
	logic                busy_q;
	logic [2:0]          done_q;
	logic                accept;
	logic                final_req;
	logic                is_matrix;

	// row-major element index from a row and a column digit.
	function automatic jac_pkg::idx_t elem_idx(input logic [1:0] r, input logic [1:0] c);
		return jac_pkg::idx_t'(r) * jac_pkg::idx_t'(jac_pkg::DIM) + jac_pkg::idx_t'(c);
	endfunction

	assign accept    = start && !busy_q;
	assign is_matrix = (mode_q == jac_pkg::MODE_MATRIX);
	assign last_step = is_matrix ? LAST_MAT : LAST_ARR;
	assign final_req = rd.valid && rd.last && (step_q == last_step);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= jac_pkg::SEQ_IDLE;
			mode_q  <= jac_pkg::MODE_MATRIX;
			step_q  <= '0;
			k_q     <= '0;
			col_q   <= '0;
			row_q   <= '0;
		end else if (accept) begin
			state_q <= jac_pkg::SEQ_RUN;
			mode_q  <= mode;
			step_q  <= '0;
			k_q     <= '0;
			col_q   <= '0;
			row_q   <= '0;
		end else if (state_q == jac_pkg::SEQ_RUN) begin
			step_q <= step_q + 5'd1;
			if (step_q == last_step) begin
				state_q <= jac_pkg::SEQ_IDLE;
			end
			// k is the inner digit in matrix mode; array mode walks the elements directly.
			if (is_matrix && k_q != DIG_MAX) begin
				k_q <= k_q + 2'd1;
			end else begin
				k_q <= '0;
				if (col_q == DIG_MAX) begin
					col_q <= '0;
					row_q <= row_q + 2'd1;
				end else begin
					col_q <= col_q + 2'd1;
				end
			end
		end
	end

	// done trails the final request by the bank and MAC latency.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			done_q <= '0;
		end else begin
			done_q <= {done_q[1:0], final_req};
			if (accept) begin
				busy_q <= 1'b1;
			end else if (done_q[2]) begin
				busy_q <= 1'b0;
			end
		end
	end

	assign busy       = busy_q;
	assign done       = done_q[2];
	assign rd.valid   = (state_q == jac_pkg::SEQ_RUN);
	assign rd.idx_a   = is_matrix ? elem_idx(row_q, k_q) : elem_idx(row_q, col_q);
	assign rd.idx_b   = is_matrix ? elem_idx(k_q, col_q) : elem_idx(row_q, col_q);
	assign rd.out_idx = elem_idx(row_q, col_q);
	assign rd.first   = is_matrix ? (k_q == '0) : 1'b1;
	assign rd.last    = is_matrix ? (k_q == DIG_MAX) : 1'b1;

	a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
		rd.valid |-> (rd.idx_a < jac_pkg::N_ELEM) && (rd.idx_b < jac_pkg::N_ELEM) &&
			(rd.out_idx < jac_pkg::N_ELEM));

	// a start during a run must not restart the schedule.
	a_run_undisturbed: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == jac_pkg::SEQ_RUN && step_q != last_step) |=>
			(state_q == jac_pkg::SEQ_RUN && step_q == $past(step_q) + 5'd1));

endmodule

`default_nettype wire

//--- test/jacobian_engine_tb.sv
// reads test/jacobian_input.txt (28 hex words per test) and runs each test through the DUT.
// every input changes 1 ns after a rising edge, and outputs are sampled at that same point.
`timescale 1ns/1ps
`default_nettype none

module jacobian_engine_tb;

	localparam int N_TESTS        = 5;
	localparam int N_ELEM         = jac_pkg::N_ELEM;
	localparam int VEC_WORDS      = 1 + 3 * N_ELEM;
	localparam int RESET_CYCLES   = 4;
	localparam int TIMEOUT_CYCLES = N_TESTS * (18 + 30 + 4) + RESET_CYCLES;

	logic          clk;
	logic          rst_n;
	logic          wr_en;
	logic          wr_sel;
	jac_pkg::idx_t wr_idx;
	jac_pkg::fix_t wr_data;
	logic          start;
	logic          mode;
	logic          busy;
	logic          res_valid;
	jac_pkg::idx_t res_idx;
	jac_pkg::fix_t res_data;
	logic          done;

	logic [17:0]   vec_mem [N_TESTS * VEC_WORDS];
	jac_pkg::fix_t results [N_ELEM];
	int            errors;
	int            failed_tests;
	int            cycle_count;

	tb_clock_gen #(
		.HALF_PERIOD  (4),
		.RESET_CYCLES (RESET_CYCLES)
	) clock_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	jacobian_engine #(
		.FRAC_BITS (15)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_sel    (wr_sel),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.start     (start),
		.mode      (mode),
		.busy      (busy),
		.res_valid (res_valid),
		.res_idx   (res_idx),
		.res_data  (res_data),
		.done      (done)
	);

	// writes A then B, one word per cycle, and checks that the engine stays idle meanwhile.
	task automatic write_operands(input int t, input int base);
		for (int i = 0; i < 2 * N_ELEM; i++) begin
			@(posedge clk);
			#1;
			assert (!busy && !res_valid && !done) else begin
				$display("test %0d: engine was not idle while operands were written", t);
				errors++;
			end
			wr_en   = 1'b1;
			wr_sel  = (i >= N_ELEM);
			wr_idx  = jac_pkg::idx_t'(i % N_ELEM);
			wr_data = jac_pkg::fix_t'(vec_mem[base + 1 + i]);
		end
	endtask

	// starts one run, pulses a second start mid-run and collects results until done.
	task automatic run_test(input int t, input int base);
		int run_len;
		int n_res;
		int n_done;
		int exp_len;
		jac_pkg::fix_t expected;

		@(posedge clk);
		#1;
		wr_en = 1'b0;
		mode  = vec_mem[base][0];
		start = 1'b1;
		exp_len = mode ? 12 : 30;
		@(posedge clk);
		#1;
		start = 1'b0;
		assert (busy) else begin
			$display("test %0d: start was not accepted", t);
			errors++;
		end
		// the acceptance cycle counts as the first cycle of the run.
		run_len = 1;
		n_res   = 0;
		n_done  = 0;
		while (n_done == 0 && run_len < 40) begin
			@(posedge clk);
			#1;
			run_len++;
			start = (run_len == 4);
			if (res_valid) begin
				assert (res_idx == jac_pkg::idx_t'(n_res)) else begin
					$display("Error at %0t: test %0d result %0d came with res_idx %0d",
						$time, t, n_res, res_idx);
					errors++;
				end
				if (res_idx < N_ELEM) begin
					results[res_idx] = res_data;
				end
				n_res++;
			end
			if (done) begin
				n_done++;
			end
		end
		start = 1'b0;

		assert (n_done == 1) else begin
			$display("test %0d: done never arrived", t);
			errors++;
		end
		assert (run_len == exp_len) else begin
			$display("test %0d: run took %0d cycles instead of %0d", t, run_len, exp_len);
			errors++;
		end
		assert (n_res == N_ELEM) else begin
			$display("test %0d: %0d results arrived instead of %0d", t, n_res, N_ELEM);
			errors++;
		end
		for (int e = 0; e < N_ELEM; e++) begin
			expected = jac_pkg::fix_t'(vec_mem[base + 1 + 2 * N_ELEM + e]);
			assert (results[e] == expected) else begin
				$display("Error at %0t: test %0d element %0d is %0d, expected %0d",
					$time, t, e, results[e], expected);
				errors++;
			end
		end
	endtask

	// a hung DUT cannot keep the run alive past the worst-case length of all tests.
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("the run timed out after %0d clock cycles", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int errors_before;

		wr_en        = 1'b0;
		wr_sel       = 1'b0;
		wr_idx       = '0;
		wr_data      = '0;
		start        = 1'b0;
		mode         = 1'b0;
		errors       = 0;
		failed_tests = 0;
		cycle_count  = 0;
		for (int e = 0; e < N_ELEM; e++) begin
			results[e] = '0;
		end
		$readmemh("test/jacobian_input.txt", vec_mem);

		wait (rst_n);
		for (int t = 0; t < N_TESTS; t++) begin
			errors_before = errors;
			write_operands(t + 1, t * VEC_WORDS);
			run_test(t + 1, t * VEC_WORDS);
			if (errors != errors_before) begin
				failed_tests++;
			end
			$display("test %0d (%s mode): %s", t + 1, mode ? "array" : "matrix",
				(errors == errors_before) ? "ok" : "failed");
		end

		$display("%0d tests run, %0d failed, %0d check errors", N_TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/jacobian_input.txt
// per test: mode (0 matrix, 1 element-wise) then A[0..8]; next line B[0..8]; next line C[0..8]
// 18-bit two's complement hex, row-major, 1.0 = 08000; C is floor(sum >> 15), saturated
// test 1: matrix, A is the identity so C equals B
00000 08000 00000 00000 00000 08000 00000 00000 00000 08000
003e8 3f830 00003 20000 1ffff 00000 03039 32bcf 0004d
003e8 3f830 00003 20000 1ffff 00000 03039 32bcf 0004d
// test 2: matrix, mixed signs with inexact sums
00000 04000 3e000 01000 38000 06000 00064 0012c 3fe0c 10000
02000 04000 3f000 3c000 000c8 08000 03000 3fd44 003e8
02600 01f76 3d87d 3b025 3c093 07003 06145 3fb1a 005b6
// test 3: element-wise, same operands as test 2
00001 04000 3e000 01000 38000 06000 00064 0012c 3fe0c 10000
02000 04000 3f000 3c000 000c8 08000 03000 3fd44 003e8
01000 3f000 3fe00 04000 00096 00064 00070 0000a 007d0
// test 4: matrix, full-scale rows and columns saturate
00000 1ffff 1ffff 1ffff 20000 20000 20000 08000 00000 00000
1ffff 20000 02000 1ffff 20000 02000 1ffff 20000 02000
1ffff 20000 17fff 20000 1ffff 28000 1ffff 20000 02000
// test 5: element-wise, saturation at both ends and floor of tiny products
00001 1ffff 20000 1ffff 20000 10000 30000 00001 3ffff 18000
1ffff 1ffff 20000 20000 10000 10000 00001 00001 18000
1ffff 20000 20000 1ffff 1ffff 20000 00000 3ffff 1ffff

//--- test/tb_clock_gen.sv
// free-running 8 ns testbench clock. rst_n is held low for RESET_CYCLES rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release just after an edge so the DUT never sees it change at the edge itself.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire
